/* verilog/riscv_dpath_pkg.sv */
/*
 * Scalar RISC-V datapath shared definitions: widths, control
 * select encodings, ALU function codes and signal bundles
 */
package riscv_dpath_pkg;

  // Data word width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // ------------------------------
  // Control select encodings
  // ------------------------------

  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMPREG} pc_sel_e;
  typedef enum logic [2:0] {BYP_RF, BYP_X, BYP_M, BYP_X2, BYP_X3, BYP_W} byp_sel_e;
  typedef enum logic [1:0] {OP0_RS1, OP0_PC, OP0_PC_PLUS4, OP0_ZERO} op0_sel_e;
  typedef enum logic [2:0] {
    OP1_RS2, OP1_SHAMT, OP1_IMM_U, OP1_IMM_SB, OP1_IMM_I, OP1_IMM_S, OP1_ZERO
  } op1_sel_e;
  typedef enum logic [2:0] {LD_WORD, LD_LB, LD_LBU, LD_LH, LD_LHU} load_sel_e;
  typedef enum logic {WB_EXEC, WB_MEM} wb_sel_e;

  // ALU functions, CP0/CP1 pass one operand through
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_CP0, ALU_CP1
  } alu_fn_e;

  // ------------------------------
  // Bundles
  // ------------------------------

  // Decoded immediates, all sign-extended except shamt
  typedef struct packed {
    word_t i;
    word_t s;
    word_t sb;
    word_t u;
    word_t uj;
    word_t shamt;
  } imm_t;

  // Later-stage results for the bypass muxes
  typedef struct packed {
    word_t x;
    word_t m;
    word_t x2;
    word_t x3;
    word_t w;
  } byp_src_t;

  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;
    logic ltu;
    logic ge;
    logic geu;
  } branch_cond_t;

  typedef struct packed {
    word_t addr;
    word_t data;
  } dmem_req_t;

  // Per-stage hold requests
  typedef struct packed {
    logic f;
    logic d;
    logic x;
    logic m;
    logic x2;
    logic x3;
    logic w;
  } stall_t;

endpackage

/* verilog/riscv_pc_unit.sv */
/*
 * PC unit: P-stage next-PC select, F-stage PC and incrementer,
 * and the PC pair carried into D
 */
`timescale 1ns/1ps

module riscv_pc_unit #(
  parameter riscv_dpath_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic                      clk,
  input  logic                      reset,
  input  riscv_dpath_pkg::pc_sel_e  pc_sel,
  input  logic                      stall_f,
  input  logic                      stall_d,
  input  riscv_dpath_pkg::word_t    branch_targ_x,
  input  riscv_dpath_pkg::word_t    jump_targ_d,
  input  riscv_dpath_pkg::word_t    jumpreg_targ_d,
  output riscv_dpath_pkg::word_t    imem_addr,
  output riscv_dpath_pkg::word_t    pc_d,
  output riscv_dpath_pkg::word_t    pc_plus4_d
);
  import riscv_dpath_pkg::*;

  word_t pc_next_p;
  word_t pc_f;
  word_t pc_plus4_f;

  // Next PC, targets come from D and X
  always_comb begin
    case (pc_sel)
      PC_BRANCH:  pc_next_p = branch_targ_x;
      PC_JUMP:    pc_next_p = jump_targ_d;
      PC_JUMPREG: pc_next_p = jumpreg_targ_d;
      default:    pc_next_p = pc_plus4_f;
    endcase
  end

  // Fetch address leaves early, in P
  assign imem_addr = reset ? RESET_VECTOR : pc_next_p;

  // F PC, the only register with a reset value
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_next_p;
    end
  end

  assign pc_plus4_f = pc_f + 32'd4;

  // D <- F
  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

endmodule

/* verilog/riscv_inst_fields.sv */
/*
 * Instruction field decode: source register indices and the
 * RV32I immediate formats
 */
`timescale 1ns/1ps

module riscv_inst_fields (
  input  riscv_dpath_pkg::word_t     inst,
  output riscv_dpath_pkg::reg_addr_t rs1,
  output riscv_dpath_pkg::reg_addr_t rs2,
  output riscv_dpath_pkg::imm_t      imm
);

  // Register specifiers
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // I and S formats, 12 bits
  assign imm.i = {{20{inst[31]}}, inst[31:20]};
  assign imm.s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

  // Branch offset, scrambled bits and implicit zero lsb
  assign imm.sb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};

  // Upper immediate fills the top 20 bits
  assign imm.u = {inst[31:12], 12'b0};

  // Jump offset, 21 bits
  assign imm.uj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};

  // Shift amount sits in the rs2 slot
  assign imm.shamt = {27'b0, inst[24:20]};

endmodule

/* verilog/riscv_regfile.sv */
/*
 * Integer register file, 32 x 32 bits, two combinational read
 * ports and one synchronous write port, x0 hardwired to zero
 */
`timescale 1ns/1ps

module riscv_regfile (
  input  logic                       clk,
  input  riscv_dpath_pkg::reg_addr_t raddr0,
  input  riscv_dpath_pkg::reg_addr_t raddr1,
  input  logic                       wen,
  input  riscv_dpath_pkg::reg_addr_t waddr,
  input  riscv_dpath_pkg::word_t     wdata,
  output riscv_dpath_pkg::word_t     rdata0,
  output riscv_dpath_pkg::word_t     rdata1
);
  import riscv_dpath_pkg::*;

  word_t regs [32];

  // Write at the clock edge, x0 never written
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle read sees the old contents
  // D must bypass from W in that case
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

/* verilog/riscv_operand_select.sv */
/*
 * D-stage operand logic: bypass and operand muxes, jump and
 * branch targets, and the D-to-X pipe register
 */
`timescale 1ns/1ps

module riscv_operand_select (
  input  logic                      clk,
  input  logic                      stall_x,
  input  riscv_dpath_pkg::byp_sel_e byp0_sel,
  input  riscv_dpath_pkg::byp_sel_e byp1_sel,
  input  riscv_dpath_pkg::op0_sel_e op0_sel,
  input  riscv_dpath_pkg::op1_sel_e op1_sel,
  input  riscv_dpath_pkg::word_t    rdata0,
  input  riscv_dpath_pkg::word_t    rdata1,
  input  riscv_dpath_pkg::imm_t     imm,
  input  riscv_dpath_pkg::byp_src_t byp_src,
  input  riscv_dpath_pkg::word_t    pc_d,
  input  riscv_dpath_pkg::word_t    pc_plus4_d,
  output riscv_dpath_pkg::word_t    op0_x,
  output riscv_dpath_pkg::word_t    op1_x,
  output riscv_dpath_pkg::word_t    wdata_x,
  output riscv_dpath_pkg::word_t    branch_targ_x,
  output riscv_dpath_pkg::word_t    jump_targ_d,
  output riscv_dpath_pkg::word_t    jumpreg_targ_d
);
  import riscv_dpath_pkg::*;

  word_t rs1_d;
  word_t rs2_d;
  word_t op0_d;
  word_t op1_d;
  word_t jumpreg_sum_d;

  // Bypass select, same for both read ports
  function automatic word_t byp_mux(input byp_sel_e sel, input word_t rf_data,
                                    input byp_src_t src);
    word_t val;
    case (sel)
      BYP_X:   val = src.x;
      BYP_M:   val = src.m;
      BYP_X2:  val = src.x2;
      BYP_X3:  val = src.x3;
      BYP_W:   val = src.w;
      default: val = rf_data;
    endcase
    return val;
  endfunction

  // ------------------------------
  // Source operands
  // ------------------------------

  assign rs1_d = byp_mux(byp0_sel, rdata0, byp_src);
  assign rs2_d = byp_mux(byp1_sel, rdata1, byp_src);

  always_comb begin
    case (op0_sel)
      OP0_PC:       op0_d = pc_d;
      OP0_PC_PLUS4: op0_d = pc_plus4_d;
      OP0_ZERO:     op0_d = '0;
      default:      op0_d = rs1_d;
    endcase
  end

  always_comb begin
    case (op1_sel)
      OP1_SHAMT:  op1_d = imm.shamt;
      OP1_IMM_U:  op1_d = imm.u;
      OP1_IMM_SB: op1_d = imm.sb;
      OP1_IMM_I:  op1_d = imm.i;
      OP1_IMM_S:  op1_d = imm.s;
      OP1_ZERO:   op1_d = '0;
      default:    op1_d = rs2_d;
    endcase
  end

  // Jump targets resolve in D
  assign jump_targ_d    = pc_d + imm.uj;
  assign jumpreg_sum_d  = rs1_d + imm.i;
  assign jumpreg_targ_d = {jumpreg_sum_d[XLEN-1:1], 1'b0};

  // ------------------------------
  // X <- D
  // ------------------------------

  // Branch target travels to X with its operands
  always_ff @(posedge clk) begin
    if (!stall_x) begin
      op0_x         <= op0_d;
      op1_x         <= op1_d;
      wdata_x       <= rs2_d;
      branch_targ_x <= pc_d + imm.sb;
    end
  end

endmodule

/* verilog/riscv_alu.sv */
/*
 * X-stage ALU for the RV32I integer operations, with the
 * branch-condition flags derived from a subtract
 */
`timescale 1ns/1ps

module riscv_alu (
  input  riscv_dpath_pkg::word_t       op0,
  input  riscv_dpath_pkg::word_t       op1,
  input  riscv_dpath_pkg::alu_fn_e     alu_fn,
  output riscv_dpath_pkg::word_t       result,
  output riscv_dpath_pkg::branch_cond_t branch_cond
);
  import riscv_dpath_pkg::*;

  logic [4:0] shamt;
  logic       diff_signs;

  // Shifts only use the low five bits
  assign shamt = op1[4:0];

  always_comb begin
    case (alu_fn)
      ALU_ADD:  result = op0 + op1;
      ALU_SUB:  result = op0 - op1;
      ALU_SLL:  result = op0 << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op0) < $signed(op1)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, op0 < op1};
      ALU_XOR:  result = op0 ^ op1;
      ALU_SRL:  result = op0 >> shamt;
      ALU_SRA:  result = $unsigned($signed(op0) >>> shamt);
      ALU_OR:   result = op0 | op1;
      ALU_AND:  result = op0 & op1;
      ALU_CP0:  result = op0;
      ALU_CP1:  result = op1;
      default:  result = '0;
    endcase
  end

  // ------------------------------
  // Branch flags, valid for SUB
  // ------------------------------

  // Differing signs decide the compare without the difference
  assign diff_signs = op0[XLEN-1] ^ op1[XLEN-1];

  assign branch_cond.eq  = (result == '0);
  assign branch_cond.ne  = ~branch_cond.eq;
  assign branch_cond.lt  = diff_signs ? op0[XLEN-1] : result[XLEN-1];
  assign branch_cond.ltu = diff_signs ? op1[XLEN-1] : result[XLEN-1];
  // ge/geu are plain inverses of lt/ltu
  assign branch_cond.ge  = ~branch_cond.lt;
  assign branch_cond.geu = ~branch_cond.ltu;

endmodule

/* verilog/riscv_mem_wb.sv */
/*
 * M stage through W: load alignment, response holding
 * register, writeback select and the X2/X3/W delay registers
 */
`timescale 1ns/1ps

module riscv_mem_wb (
  input  logic                       clk,
  input  logic                       stall_m,
  input  logic                       stall_x2,
  input  logic                       stall_x3,
  input  logic                       stall_w,
  input  riscv_dpath_pkg::word_t     exec_x,
  input  riscv_dpath_pkg::word_t     dmem_resp_data,
  input  riscv_dpath_pkg::load_sel_e load_sel,
  input  logic                       resp_hold_en,
  input  logic                       resp_hold_use,
  input  riscv_dpath_pkg::wb_sel_e   wb_sel,
  output riscv_dpath_pkg::word_t     result_m,
  output riscv_dpath_pkg::word_t     result_x2,
  output riscv_dpath_pkg::word_t     result_x3,
  output riscv_dpath_pkg::word_t     result_w
);
  import riscv_dpath_pkg::*;

  word_t exec_m;
  word_t load_m;
  word_t resp_hold;
  word_t resp_m;

  // M <- X
  always_ff @(posedge clk) begin
    if (!stall_m) begin
      exec_m <= exec_x;
    end
  end

  // ------------------------------
  // Load alignment
  // ------------------------------

  always_comb begin
    case (load_sel)
      LD_LB:   load_m = {{24{dmem_resp_data[7]}}, dmem_resp_data[7:0]};
      LD_LBU:  load_m = {24'b0, dmem_resp_data[7:0]};
      LD_LH:   load_m = {{16{dmem_resp_data[15]}}, dmem_resp_data[15:0]};
      LD_LHU:  load_m = {16'b0, dmem_resp_data[15:0]};
      default: load_m = dmem_resp_data;
    endcase
  end

  // One-entry holding slot for an early response
  always_ff @(posedge clk) begin
    if (resp_hold_en) begin
      resp_hold <= load_m;
    end
  end

  assign resp_m = resp_hold_use ? resp_hold : load_m;

  // Writeback select happens in M
  assign result_m = (wb_sel == WB_MEM) ? resp_m : exec_m;

  // ------------------------------
  // X2, X3 and W delay
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!stall_x2) begin
      result_x2 <= result_m;
    end
    if (!stall_x3) begin
      result_x3 <= result_x2;
    end
    if (!stall_w) begin
      result_w <= result_x3;
    end
  end

endmodule

/* verilog/riscv_dpath.sv */
/*
 * Seven-stage RISC-V scalar integer datapath top level,
 * driven by an external control unit
 */
`timescale 1ns/1ps

module riscv_dpath #(
  parameter riscv_dpath_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic                         clk,
  input  logic                         reset,
  input  riscv_dpath_pkg::pc_sel_e     pc_sel,
  input  riscv_dpath_pkg::word_t       inst,
  input  riscv_dpath_pkg::byp_sel_e    byp0_sel,
  input  riscv_dpath_pkg::byp_sel_e    byp1_sel,
  input  riscv_dpath_pkg::op0_sel_e    op0_sel,
  input  riscv_dpath_pkg::op1_sel_e    op1_sel,
  input  riscv_dpath_pkg::alu_fn_e     alu_fn,
  input  riscv_dpath_pkg::load_sel_e   load_sel,
  input  logic                         resp_hold_en,
  input  logic                         resp_hold_use,
  input  riscv_dpath_pkg::wb_sel_e     wb_sel,
  input  riscv_dpath_pkg::word_t       dmem_resp_data,
  input  logic                         rf_wen,
  input  riscv_dpath_pkg::reg_addr_t   rf_waddr,
  input  riscv_dpath_pkg::stall_t      stall,
  output riscv_dpath_pkg::word_t       imem_addr,
  output riscv_dpath_pkg::dmem_req_t   dmem_req,
  output riscv_dpath_pkg::branch_cond_t branch_cond,
  output riscv_dpath_pkg::word_t       csr_wdata
);
  import riscv_dpath_pkg::*;

  // P/F/D
  word_t     pc_d;
  word_t     pc_plus4_d;
  word_t     jump_targ_d;
  word_t     jumpreg_targ_d;
  reg_addr_t rs1_d;
  reg_addr_t rs2_d;
  imm_t      imm_d;
  word_t     rdata0_d;
  word_t     rdata1_d;
  byp_src_t  byp_src;

  // X and later
  word_t op0_x;
  word_t op1_x;
  word_t wdata_x;
  word_t branch_targ_x;
  word_t result_x;
  word_t result_m;
  word_t result_x2;
  word_t result_x3;
  word_t result_w;

  // ------------------------------
  // Fetch and decode
  // ------------------------------

  riscv_pc_unit #(
    .RESET_VECTOR (RESET_VECTOR)
  ) i_pc_unit (
    .clk            (clk),
    .reset          (reset),
    .pc_sel         (pc_sel),
    .stall_f        (stall.f),
    .stall_d        (stall.d),
    .branch_targ_x  (branch_targ_x),
    .jump_targ_d    (jump_targ_d),
    .jumpreg_targ_d (jumpreg_targ_d),
    .imem_addr      (imem_addr),
    .pc_d           (pc_d),
    .pc_plus4_d     (pc_plus4_d)
  );

  riscv_inst_fields i_inst_fields (
    .inst (inst),
    .rs1  (rs1_d),
    .rs2  (rs2_d),
    .imm  (imm_d)
  );

  // Written from W, read in D
  riscv_regfile i_regfile (
    .clk    (clk),
    .raddr0 (rs1_d),
    .raddr1 (rs2_d),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (result_w),
    .rdata0 (rdata0_d),
    .rdata1 (rdata1_d)
  );

  // Bypass sources from every later stage
  assign byp_src.x  = result_x;
  assign byp_src.m  = result_m;
  assign byp_src.x2 = result_x2;
  assign byp_src.x3 = result_x3;
  assign byp_src.w  = result_w;

  riscv_operand_select i_operand_select (
    .clk            (clk),
    .stall_x        (stall.x),
    .byp0_sel       (byp0_sel),
    .byp1_sel       (byp1_sel),
    .op0_sel        (op0_sel),
    .op1_sel        (op1_sel),
    .rdata0         (rdata0_d),
    .rdata1         (rdata1_d),
    .imm            (imm_d),
    .byp_src        (byp_src),
    .pc_d           (pc_d),
    .pc_plus4_d     (pc_plus4_d),
    .op0_x          (op0_x),
    .op1_x          (op1_x),
    .wdata_x        (wdata_x),
    .branch_targ_x  (branch_targ_x),
    .jump_targ_d    (jump_targ_d),
    .jumpreg_targ_d (jumpreg_targ_d)
  );

  // ------------------------------
  // Execute through writeback
  // ------------------------------

  riscv_alu i_alu (
    .op0         (op0_x),
    .op1         (op1_x),
    .alu_fn      (alu_fn),
    .result      (result_x),
    .branch_cond (branch_cond)
  );

  // Data request goes out in X
  assign dmem_req.addr = result_x;
  assign dmem_req.data = wdata_x;

  riscv_mem_wb i_mem_wb (
    .clk            (clk),
    .stall_m        (stall.m),
    .stall_x2       (stall.x2),
    .stall_x3       (stall.x3),
    .stall_w        (stall.w),
    .exec_x         (result_x),
    .dmem_resp_data (dmem_resp_data),
    .load_sel       (load_sel),
    .resp_hold_en   (resp_hold_en),
    .resp_hold_use  (resp_hold_use),
    .wb_sel         (wb_sel),
    .result_m       (result_m),
    .result_x2      (result_x2),
    .result_x3      (result_x3),
    .result_w       (result_w)
  );

  // W word doubles as CSR write data
  assign csr_wdata = result_w;

endmodule

/* verification/riscv_dpath_assert.sv */
/*
 * Bound checker on the datapath ports covering fetch sequencing,
 * fixed pipeline latencies, bypass values, branch flags and loads
 */
`timescale 1ns/1ps

module riscv_dpath_assert #(
  parameter riscv_dpath_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input logic                          clk,
  input logic                          reset,
  input riscv_dpath_pkg::pc_sel_e      pc_sel,
  input riscv_dpath_pkg::word_t        inst,
  input riscv_dpath_pkg::byp_sel_e     byp0_sel,
  input riscv_dpath_pkg::byp_sel_e     byp1_sel,
  input riscv_dpath_pkg::op0_sel_e     op0_sel,
  input riscv_dpath_pkg::op1_sel_e     op1_sel,
  input riscv_dpath_pkg::alu_fn_e      alu_fn,
  input riscv_dpath_pkg::load_sel_e    load_sel,
  input logic                          resp_hold_en,
  input logic                          resp_hold_use,
  input riscv_dpath_pkg::wb_sel_e      wb_sel,
  input riscv_dpath_pkg::word_t        dmem_resp_data,
  input logic                          rf_wen,
  input riscv_dpath_pkg::reg_addr_t    rf_waddr,
  input riscv_dpath_pkg::stall_t       stall,
  input riscv_dpath_pkg::word_t        imem_addr,
  input riscv_dpath_pkg::dmem_req_t    dmem_req,
  input riscv_dpath_pkg::branch_cond_t branch_cond,
  input riscv_dpath_pkg::word_t        csr_wdata
);
  import riscv_dpath_pkg::*;

  int    fail_count = 0;
  int    age;
  word_t shadow [32];
  word_t held;
  word_t rf_expect0;
  word_t rf_expect1;
  word_t load_expect;
  word_t mem_expect;

  function automatic word_t sext_i(input word_t w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  // Jump offset from the UJ layout
  function automatic word_t uj_off(input word_t w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic branch_cond_t flags(input word_t a, input word_t b);
    branch_cond_t f;
    f.eq  = (a == b);
    f.ne  = (a != b);
    f.lt  = ($signed(a) < $signed(b));
    f.ltu = (a < b);
    f.ge  = ($signed(a) >= $signed(b));
    f.geu = (a >= b);
    return f;
  endfunction

  // ------------------------------
  // Reference state
  // ------------------------------

  // Cycles since reset gate the checks that look back
  always_ff @(posedge clk) begin
    if (reset) begin
      age <= 0;
    end else if (age < 15) begin
      age <= age + 1;
    end
  end

  // Shadow register file filled from W
  always_ff @(posedge clk) begin
    if (rf_wen && rf_waddr != '0) begin
      shadow[rf_waddr] <= csr_wdata;
    end
    if (resp_hold_en) begin
      held <= load_expect;
    end
  end

  assign rf_expect0 = (inst[19:15] == '0) ? '0 : shadow[inst[19:15]];
  assign rf_expect1 = (inst[24:20] == '0) ? '0 : shadow[inst[24:20]];

  always_comb begin
    case (load_sel)
      LD_LB:   load_expect = {{24{dmem_resp_data[7]}}, dmem_resp_data[7:0]};
      LD_LBU:  load_expect = {24'h0, dmem_resp_data[7:0]};
      LD_LH:   load_expect = {{16{dmem_resp_data[15]}}, dmem_resp_data[15:0]};
      LD_LHU:  load_expect = {16'h0, dmem_resp_data[15:0]};
      default: load_expect = dmem_resp_data;
    endcase
  end

  assign mem_expect = resp_hold_use ? held : load_expect;

  // ------------------------------
  // Fetch
  // ------------------------------

  a_reset_vec: assert property (@(posedge clk) reset |-> imem_addr == RESET_VECTOR)
    else begin $error("MISMATCH imem_addr %h in reset", imem_addr); fail_count++; end

  a_seq: assert property (@(posedge clk) disable iff (reset || age < 1)
    pc_sel == PC_PLUS4 |->
      imem_addr == $past(imem_addr) + ($past(stall.f) ? 32'd0 : 32'd4))
    else begin $error("MISMATCH imem_addr %h sequencing", imem_addr); fail_count++; end

  a_jump: assert property (@(posedge clk) disable iff (reset || age < 3)
    pc_sel == PC_JUMP && !$past(stall.f, 2) |->
      imem_addr == $past(imem_addr, 2) + uj_off(inst))
    else begin $error("MISMATCH imem_addr %h jump", imem_addr); fail_count++; end

  a_jumpreg: assert property (@(posedge clk) disable iff (reset)
    pc_sel == PC_JUMPREG && byp0_sel == BYP_RF |->
      imem_addr == ((rf_expect0 + sext_i(inst)) & ~32'd1))
    else begin $error("MISMATCH imem_addr %h jumpreg", imem_addr); fail_count++; end

  // ------------------------------
  // Execute and bypass
  // ------------------------------

  a_imm: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op0_sel == OP0_ZERO && op1_sel == OP1_IMM_I) && alu_fn == ALU_ADD |->
      dmem_req.addr == sext_i($past(inst)))
    else begin $error("MISMATCH dmem_req.addr %h imm", dmem_req.addr); fail_count++; end

  a_byp_x: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op0_sel == OP0_RS1 && byp0_sel == BYP_X && op1_sel == OP1_IMM_I)
      && alu_fn == ALU_ADD |->
      dmem_req.addr == $past(dmem_req.addr) + sext_i($past(inst)))
    else begin $error("MISMATCH dmem_req.addr %h byp X", dmem_req.addr); fail_count++; end

  a_byp_m: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op0_sel == OP0_RS1 && byp0_sel == BYP_M && op1_sel == OP1_IMM_I
      && wb_sel == WB_EXEC) && alu_fn == ALU_ADD |->
      dmem_req.addr == $past(dmem_req.addr, 2) + sext_i($past(inst)))
    else begin $error("MISMATCH dmem_req.addr %h byp M", dmem_req.addr); fail_count++; end

  a_byp_w: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op0_sel == OP0_RS1 && byp0_sel == BYP_W && op1_sel == OP1_IMM_I)
      && alu_fn == ALU_ADD |->
      dmem_req.addr == $past(csr_wdata) + sext_i($past(inst)))
    else begin $error("MISMATCH dmem_req.addr %h byp W", dmem_req.addr); fail_count++; end

  a_rf_read: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op0_sel == OP0_RS1 && byp0_sel == BYP_RF) && alu_fn == ALU_CP0 |->
      dmem_req.addr == $past(rf_expect0))
    else begin $error("MISMATCH dmem_req.addr %h rf read", dmem_req.addr); fail_count++; end

  a_branch: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op0_sel == OP0_RS1 && byp0_sel == BYP_RF && op1_sel == OP1_RS2
      && byp1_sel == BYP_RF) && alu_fn == ALU_SUB |->
      branch_cond == flags($past(rf_expect0), $past(rf_expect1)))
    else begin $error("MISMATCH branch_cond %h", branch_cond); fail_count++; end

  // Store data is the rs2 word carried into X
  a_store_data: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(op1_sel == OP1_RS2 && byp1_sel == BYP_RF) |->
      dmem_req.data == $past(rf_expect1))
    else begin $error("MISMATCH dmem_req.data %h", dmem_req.data); fail_count++; end

  // ------------------------------
  // Writeback latency
  // ------------------------------

  a_wb_exec: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(wb_sel == WB_EXEC, 3) |-> csr_wdata == $past(dmem_req.addr, 4))
    else begin $error("MISMATCH csr_wdata %h exec", csr_wdata); fail_count++; end

  a_wb_mem: assert property (@(posedge clk) disable iff (reset || age < 6)
    $past(wb_sel == WB_MEM, 3) |-> csr_wdata == $past(mem_expect, 3))
    else begin $error("MISMATCH csr_wdata %h load", csr_wdata); fail_count++; end

endmodule

bind riscv_dpath riscv_dpath_assert #(.RESET_VECTOR(RESET_VECTOR)) i_assert (.*);

/* verification/riscv_dpath_tb.sv */
/*
 * Datapath testbench acting as the control unit and driving
 * each test sequence
 */
`timescale 1ns/1ps

module riscv_dpath_tb;
  import riscv_dpath_pkg::*;

  localparam int MAX_CYCLES = 2000;

  logic         clk;
  logic         reset;
  pc_sel_e      pc_sel;
  word_t        inst;
  byp_sel_e     byp0_sel;
  byp_sel_e     byp1_sel;
  op0_sel_e     op0_sel;
  op1_sel_e     op1_sel;
  alu_fn_e      alu_fn;
  load_sel_e    load_sel;
  logic         resp_hold_en;
  logic         resp_hold_use;
  wb_sel_e      wb_sel;
  word_t        dmem_resp_data;
  logic         rf_wen;
  reg_addr_t    rf_waddr;
  stall_t       stall;
  word_t        imem_addr;
  dmem_req_t    dmem_req;
  branch_cond_t branch_cond;
  word_t        csr_wdata;

  int seed = 32'h7954;
  int cycles = 0;
  int tests = 0;
  int failed_tests = 0;
  int mark = 0;

  logic [11:0] pair_a;
  logic [11:0] pair_b;

  riscv_dpath i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hard stop on a hung run
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic step(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Bubble in D
  task automatic idle_d();
    inst     = '0;
    byp0_sel = BYP_RF;
    byp1_sel = BYP_RF;
    op0_sel  = OP0_ZERO;
    op1_sel  = OP1_ZERO;
  endtask

  task automatic issue(input word_t w, input op0_sel_e o0, input byp_sel_e b0,
                       input op1_sel_e o1, input byp_sel_e b1);
    inst     = w;
    op0_sel  = o0;
    byp0_sel = b0;
    op1_sel  = o1;
    byp1_sel = b1;
  endtask

  // Immediate written into a register five edges after issue
  task automatic write_reg(input reg_addr_t rd, input logic [11:0] imm12);
    alu_fn = ALU_ADD;
    issue({imm12, 20'h0}, OP0_ZERO, BYP_RF, OP1_IMM_I, BYP_RF);
    step(1);
    idle_d();
    step(4);
    rf_wen   = 1'b1;
    rf_waddr = rd;
    step(1);
    rf_wen = 1'b0;
  endtask

  task automatic report(input string name);
    int errs;
    step(6);
    errs = i_dut.i_assert.fail_count - mark;
    mark = i_dut.i_assert.fail_count;
    tests++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %s : %0d assertion failures", name, errs);
  endtask

  initial begin
    reset = 1'b1;
    pc_sel = PC_PLUS4;
    idle_d();
    alu_fn = ALU_ADD;
    load_sel = LD_WORD;
    resp_hold_en = 1'b0;
    resp_hold_use = 1'b0;
    wb_sel = WB_EXEC;
    dmem_resp_data = '0;
    rf_wen = 1'b0;
    rf_waddr = '0;
    stall = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Sequencing with a few fetch stalls
    step(3);
    stall.f = 1'b1;
    step(2);
    stall.f = 1'b0;
    report("sequence");

    // Back-to-back immediates
    for (int i = 0; i < 6; i++) begin
      issue({$random(seed)} & 32'hfff0_0000, OP0_ZERO, BYP_RF, OP1_IMM_I, BYP_RF);
      step(1);
    end
    idle_d();
    report("immediate");

    // Register file readback followed by X, M and W bypass
    write_reg(5'd3, 12'h9a5);
    alu_fn = ALU_CP0;
    issue({12'h0, 5'd3, 15'h0}, OP0_RS1, BYP_RF, OP1_ZERO, BYP_RF);
    step(1);
    idle_d();
    step(1);
    alu_fn = ALU_ADD;
    issue(32'h0120_0000, OP0_ZERO, BYP_RF, OP1_IMM_I, BYP_RF);
    step(1);
    issue(32'h0030_0000, OP0_RS1, BYP_X, OP1_IMM_I, BYP_RF);
    step(1);
    issue(32'hff50_0000, OP0_RS1, BYP_M, OP1_IMM_I, BYP_RF);
    step(1);
    idle_d();
    step(2);
    issue(32'h7ff0_0000, OP0_RS1, BYP_W, OP1_IMM_I, BYP_RF);
    step(1);
    idle_d();
    report("bypass");

    // Branch flags on random pairs and one equal pair
    for (int i = 0; i < 5; i++) begin
      pair_a = 12'($random(seed));
      pair_b = (i == 4) ? pair_a : 12'($random(seed));
      write_reg(5'd5, pair_a);
      write_reg(5'd6, pair_b);
      alu_fn = ALU_SUB;
      issue({7'h0, 5'd6, 5'd5, 15'h0}, OP0_RS1, BYP_RF, OP1_RS2, BYP_RF);
      step(1);
      idle_d();
      step(1);
    end
    alu_fn = ALU_ADD;
    report("branch");

    // Every extension and then a held response
    // Byte and half sign bits forced high
    for (int i = 0; i < 5; i++) begin
      wb_sel = WB_MEM;
      load_sel = load_sel_e'(i);
      dmem_resp_data = $random(seed) | 32'h0000_8080;
      step(1);
    end
    wb_sel = WB_EXEC;
    load_sel = LD_LH;
    dmem_resp_data = $random(seed);
    resp_hold_en = 1'b1;
    step(1);
    resp_hold_en = 1'b0;
    load_sel = LD_WORD;
    dmem_resp_data = $random(seed);
    step(2);
    wb_sel = WB_MEM;
    resp_hold_use = 1'b1;
    step(1);
    resp_hold_use = 1'b0;
    wb_sel = WB_EXEC;
    report("load");

    // JUMP from a random UJ word and JUMPREG from x7
    inst = $random(seed);
    pc_sel = PC_JUMP;
    step(1);
    pc_sel = PC_PLUS4;
    idle_d();
    write_reg(5'd7, 12'h3a1);
    // Odd sum so the target drops bit 0
    issue({12'h014, 5'd7, 15'h0}, OP0_ZERO, BYP_RF, OP1_ZERO, BYP_RF);
    pc_sel = PC_JUMPREG;
    step(1);
    pc_sel = PC_PLUS4;
    idle_d();
    report("jump");

    $display("Tests %0d, failed %0d, assertion failures %0d",
             tests, failed_tests, i_dut.i_assert.fail_count);
    if (failed_tests == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* riscv_dpath.f */
verilog/riscv_dpath_pkg.sv
verilog/riscv_pc_unit.sv
verilog/riscv_inst_fields.sv
verilog/riscv_regfile.sv
verilog/riscv_operand_select.sv
verilog/riscv_alu.sv
verilog/riscv_mem_wb.sv
verilog/riscv_dpath.sv
verification/riscv_dpath_assert.sv
verification/riscv_dpath_tb.sv
